// File: hw/ioPkg.sv
package ioPkg;

  // bus and register widths
  localparam int dataWidth = 8;
  localparam int addrWidth = 8;

  // front panel population
  localparam int numDigits = 8;
  localparam int digitIdxWidth = $clog2(numDigits);
  localparam int numButtons = 21;
  localparam int buttonIdxWidth = $clog2(numButtons);
  localparam int buttonByteCount = 3; // 21 buttons packed into three bytes

  // address map, local to the peripheral page
  localparam logic [addrWidth-1:0] digitBase = addrWidth'(0);  // digits at 0 to 7
  localparam logic [addrWidth-1:0] ledLeftAddr = addrWidth'(8);
  localparam logic [addrWidth-1:0] ledRightAddr = addrWidth'(9);
  localparam logic [addrWidth-1:0] buttonBase = addrWidth'(10); // raw bytes at 10 to 12
  localparam logic [addrWidth-1:0] buttonIndexAddr = addrWidth'(13);

  // all segments lit for values outside the glyph table
  localparam logic [dataWidth-1:0] blankGlyph = '1;

  // request held in the bus port output stage
  typedef enum logic [1:0] {
    opIdle,
    opRead,
    opWrite
  } busOp;

endpackage

// File: hw/ioBusPort.sv
`timescale 1ns/1ps

module ioBusPort (
  input  logic                                             clk,
  input  logic                                             nrst,
  input  logic                                             cyc,
  input  logic                                             stb,
  input  logic                                             we,
  input  logic [ioPkg::addrWidth-1:0]                      adr,
  input  logic [ioPkg::dataWidth-1:0]                      datIn,
  input  logic [ioPkg::dataWidth-1:0]                      rdData,
  input  logic [ioPkg::buttonByteCount*ioPkg::dataWidth-1:0] buttonBytes,
  input  logic [ioPkg::dataWidth-1:0]                      buttonIndex,
  output logic                                             ack,
  output logic [ioPkg::dataWidth-1:0]                      datOut,
  output ioPkg::busOp                                      op,
  output logic [ioPkg::addrWidth-1:0]                      regAddr,
  output logic [ioPkg::dataWidth-1:0]                      regData
);

  logic request;
  logic [ioPkg::addrWidth-1:0] slotAddr;
  logic [ioPkg::dataWidth-1:0] slotData;
  logic [ioPkg::addrWidth-1:0] byteOffset;
  logic [ioPkg::dataWidth-1:0] readValue;
  ioPkg::busOp slotOp;

  // new request only while no ack is pending
  assign request = cyc & stb & ~ack;

  // lookup runs on the live address, commit uses the slot
  assign regAddr = ack ? slotAddr : adr;
  assign regData = slotData;
  assign op = slotOp;

  assign byteOffset = adr - ioPkg::buttonBase;

  // read source by address range
  always_comb begin
    readValue = rdData; // bank returns zero outside its own range
    for (int b = 0; b < ioPkg::buttonByteCount; b++) begin
      if (byteOffset == b) begin
        readValue = buttonBytes[b*ioPkg::dataWidth +: ioPkg::dataWidth];
      end
    end
    if (adr == ioPkg::buttonIndexAddr) begin
      readValue = buttonIndex;
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      ack <= 1'b0;
      slotOp <= ioPkg::opIdle;
      datOut <= '0;
    end else begin
      ack <= request; // exactly one cycle since request needs ack low
      if (request) begin
        slotOp <= we ? ioPkg::opWrite : ioPkg::opRead;
        datOut <= we ? '0 : readValue;
      end else begin
        slotOp <= ioPkg::opIdle;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (request) begin
      slotAddr <= adr;
      slotData <= datIn;
    end
  end

endmodule

// File: hw/segGlyphEncoder.sv
`timescale 1ns/1ps

module segGlyphEncoder (
  input  logic [ioPkg::dataWidth-1:0] value,
  output logic [ioPkg::dataWidth-1:0] glyph
);

  // bit 7 is the decimal point, bits 6..0 are segments g..a
  always_comb begin
    case (value)
      8'd0:    glyph = 8'b1011_1111; // zero with point
      8'd1:    glyph = 8'b0000_0110;
      8'd2:    glyph = 8'b0101_1011;
      8'd3:    glyph = 8'b0100_1111;
      8'd4:    glyph = 8'b0110_0110;
      8'd5:    glyph = 8'b0110_1101;
      8'd6:    glyph = 8'b0111_1101;
      8'd7:    glyph = 8'b0000_0111;
      8'd8:    glyph = 8'b0111_1111;
      8'd9:    glyph = 8'b0110_1111;
      8'd10:   glyph = 8'b0111_0111; // A
      8'd11:   glyph = 8'b0111_1100; // b
      8'd12:   glyph = 8'b0011_1001; // C
      8'd13:   glyph = 8'b0101_1110; // d
      8'd14:   glyph = 8'b0111_1001; // E
      8'd15:   glyph = 8'b0111_0001; // F

      // letters
      8'd16:   glyph = 8'b0111_0110; // H
      8'd17:   glyph = 8'b0011_1110; // w-like
      8'd18:   glyph = 8'b0101_1100; // small o
      8'd19:   glyph = 8'b0101_0000; // r

      // segment ring symbols
      8'h22:   glyph = 8'b1111_1100;
      8'h23:   glyph = 8'b1111_0000;
      8'h24:   glyph = 8'b1111_1000;
      8'h46:   glyph = 8'b1101_0000; // r with point

      default: glyph = ioPkg::blankGlyph;
    endcase
  end

endmodule

// File: hw/ioRegisterBank.sv
`timescale 1ns/1ps

module ioRegisterBank (
  input  logic                        clk,
  input  logic                        nrst,
  input  ioPkg::busOp                 op,
  input  logic [ioPkg::addrWidth-1:0] regAddr,
  input  logic [ioPkg::dataWidth-1:0] regData,
  input  logic [ioPkg::dataWidth-1:0] glyph,
  output logic [ioPkg::dataWidth-1:0] digit0,
  output logic [ioPkg::dataWidth-1:0] digit1,
  output logic [ioPkg::dataWidth-1:0] digit2,
  output logic [ioPkg::dataWidth-1:0] digit3,
  output logic [ioPkg::dataWidth-1:0] digit4,
  output logic [ioPkg::dataWidth-1:0] digit5,
  output logic [ioPkg::dataWidth-1:0] digit6,
  output logic [ioPkg::dataWidth-1:0] digit7,
  output logic [ioPkg::dataWidth-1:0] ledLeft,
  output logic [ioPkg::dataWidth-1:0] ledRight,
  output logic [ioPkg::dataWidth-1:0] rdData
);

  logic [ioPkg::dataWidth-1:0] digitReg [ioPkg::numDigits];
  logic [ioPkg::addrWidth-1:0] digitOffset;
  logic [ioPkg::digitIdxWidth-1:0] digitSel;
  logic isDigit;
  logic isLeft;
  logic isRight;
  logic commit;

  // address decode
  assign digitOffset = regAddr - ioPkg::digitBase;
  assign digitSel = digitOffset[ioPkg::digitIdxWidth-1:0];
  assign isDigit = digitOffset < ioPkg::numDigits;
  assign isLeft = regAddr == ioPkg::ledLeftAddr;
  assign isRight = regAddr == ioPkg::ledRightAddr;
  assign commit = op == ioPkg::opWrite;

  // digits take the encoded glyph, LEDs the raw byte
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      for (int d = 0; d < ioPkg::numDigits; d++) begin
        digitReg[d] <= '0;
      end
      ledLeft <= '0;
      ledRight <= '0;
    end else if (commit) begin
      if (isDigit) begin
        digitReg[digitSel] <= glyph;
      end
      if (isLeft) begin
        ledLeft <= regData;
      end
      if (isRight) begin
        ledRight <= regData;
      end
    end
  end

  // readback, a committing write wins over the stored value
  always_comb begin
    rdData = '0;
    if (isDigit) begin
      rdData = commit ? glyph : digitReg[digitSel];
    end else if (isLeft) begin
      rdData = commit ? regData : ledLeft;
    end else if (isRight) begin
      rdData = commit ? regData : ledRight;
    end
  end

  assign digit0 = digitReg[0];
  assign digit1 = digitReg[1];
  assign digit2 = digitReg[2];
  assign digit3 = digitReg[3];
  assign digit4 = digitReg[4];
  assign digit5 = digitReg[5];
  assign digit6 = digitReg[6];
  assign digit7 = digitReg[7];

endmodule

// File: hw/buttonScanner.sv
`timescale 1ns/1ps

module buttonScanner (
  input  logic                                               clk,
  input  logic                                               nrst,
  input  logic [ioPkg::numButtons-1:0]                       buttons,
  output logic [ioPkg::buttonByteCount*ioPkg::dataWidth-1:0] buttonBytes,
  output logic [ioPkg::dataWidth-1:0]                        buttonIndex
);

  localparam int padBits = ioPkg::buttonByteCount * ioPkg::dataWidth - ioPkg::numButtons;
  localparam int idxPadBits = ioPkg::dataWidth - 1 - ioPkg::buttonIdxWidth;

  logic [ioPkg::numButtons-1:0] syncMeta;
  logic [ioPkg::numButtons-1:0] syncOut;
  logic [ioPkg::buttonIdxWidth-1:0] lowIdx;
  logic anyPressed;

  // two flop synchronizer
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      syncMeta <= '0;
      syncOut <= '0;
    end else begin
      syncMeta <= buttons;
      syncOut <= syncMeta;
    end
  end

  // upper bits of the last byte stay zero
  assign buttonBytes = {{padBits{1'b0}}, syncOut};

  // lowest set bit wins, so scan from the top down
  always_comb begin
    lowIdx = '0;
    for (int i = ioPkg::numButtons - 1; i >= 0; i--) begin
      if (syncOut[i]) begin
        lowIdx = ioPkg::buttonIdxWidth'(i);
      end
    end
  end

  assign anyPressed = |syncOut;

  // valid flag in bit 7, index in the low bits
  assign buttonIndex = {anyPressed, {idxPadBits{1'b0}}, lowIdx};

endmodule

// File: hw/fpgaIoTop.sv
`timescale 1ns/1ps

module fpgaIoTop (
  input  logic                         clk,
  input  logic                         nrst,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [ioPkg::addrWidth-1:0]  adr,
  input  logic [ioPkg::dataWidth-1:0]  datIn,
  input  logic [ioPkg::numButtons-1:0] buttons,
  output logic                         ack,
  output logic [ioPkg::dataWidth-1:0]  datOut,
  output logic [ioPkg::dataWidth-1:0]  digit0,
  output logic [ioPkg::dataWidth-1:0]  digit1,
  output logic [ioPkg::dataWidth-1:0]  digit2,
  output logic [ioPkg::dataWidth-1:0]  digit3,
  output logic [ioPkg::dataWidth-1:0]  digit4,
  output logic [ioPkg::dataWidth-1:0]  digit5,
  output logic [ioPkg::dataWidth-1:0]  digit6,
  output logic [ioPkg::dataWidth-1:0]  digit7,
  output logic [ioPkg::dataWidth-1:0]  ledLeft,
  output logic [ioPkg::dataWidth-1:0]  ledRight
);

  ioPkg::busOp op;
  logic [ioPkg::addrWidth-1:0] regAddr;
  logic [ioPkg::dataWidth-1:0] regData;
  logic [ioPkg::dataWidth-1:0] glyph;
  logic [ioPkg::dataWidth-1:0] rdData;
  logic [ioPkg::buttonByteCount*ioPkg::dataWidth-1:0] buttonBytes;
  logic [ioPkg::dataWidth-1:0] buttonIndex;

  ioBusPort busPort_i (
    .clk(clk), .nrst(nrst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
    .rdData(rdData), .buttonBytes(buttonBytes), .buttonIndex(buttonIndex),
    .ack(ack), .datOut(datOut), .op(op), .regAddr(regAddr), .regData(regData)
  );

  // glyph follows the request slot data
  segGlyphEncoder glyphEnc_i (
    .value(regData),
    .glyph(glyph)
  );

  ioRegisterBank regBank_i (
    .clk(clk), .nrst(nrst), .op(op), .regAddr(regAddr), .regData(regData), .glyph(glyph),
    .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3),
    .digit4(digit4), .digit5(digit5), .digit6(digit6), .digit7(digit7),
    .ledLeft(ledLeft), .ledRight(ledRight), .rdData(rdData)
  );

  buttonScanner scanner_i (
    .clk(clk),
    .nrst(nrst),
    .buttons(buttons),
    .buttonBytes(buttonBytes),
    .buttonIndex(buttonIndex)
  );

endmodule

// File: dv/fpgaIo_chk.sv
`timescale 1ns/1ps

module fpgaIoChk (
  input logic                        clk,
  input logic                        nrst,
  input logic                        cyc,
  input logic                        stb,
  input logic                        ack,
  input logic [ioPkg::dataWidth-1:0] digit0,
  input logic [ioPkg::dataWidth-1:0] digit1,
  input logic [ioPkg::dataWidth-1:0] digit2,
  input logic [ioPkg::dataWidth-1:0] digit3,
  input logic [ioPkg::dataWidth-1:0] digit4,
  input logic [ioPkg::dataWidth-1:0] digit5,
  input logic [ioPkg::dataWidth-1:0] digit6,
  input logic [ioPkg::dataWidth-1:0] digit7,
  input logic [ioPkg::dataWidth-1:0] ledLeft,
  input logic [ioPkg::dataWidth-1:0] ledRight
);

  logic panelDark;

  assign panelDark = (digit0 | digit1 | digit2 | digit3 | digit4 | digit5 | digit6 | digit7 |
                      ledLeft | ledRight) == '0;

  // slave acks in exactly one cycle
  ackSinglePulse: assert property (@(posedge clk) disable iff (!nrst) ack |=> !ack)
    else $error("ack stayed high for more than one cycle");

  ackAfterRequest: assert property (@(posedge clk) disable iff (!nrst)
    $rose(ack) |-> $past(cyc && stb))
    else $error("ack rose without a cyc and stb request");

  quietInReset: assert property (@(posedge clk) (!nrst && $past(!nrst)) |-> (!ack && panelDark))
    else $error("ack or a panel output is nonzero during reset");

endmodule

bind fpgaIoTop fpgaIoChk chk_i (.*);

// File: dv/fpgaIoTb.sv
`timescale 1ns/1ps

module fpgaIoTb;

  logic clk;
  logic nrst;
  logic cyc;
  logic stb;
  logic we;
  logic [ioPkg::addrWidth-1:0] adr;
  logic [ioPkg::dataWidth-1:0] datIn;
  logic [ioPkg::numButtons-1:0] buttons;
  logic ack;
  logic [ioPkg::dataWidth-1:0] datOut;
  logic [ioPkg::dataWidth-1:0] digit0;
  logic [ioPkg::dataWidth-1:0] digit1;
  logic [ioPkg::dataWidth-1:0] digit2;
  logic [ioPkg::dataWidth-1:0] digit3;
  logic [ioPkg::dataWidth-1:0] digit4;
  logic [ioPkg::dataWidth-1:0] digit5;
  logic [ioPkg::dataWidth-1:0] digit6;
  logic [ioPkg::dataWidth-1:0] digit7;
  logic [ioPkg::dataWidth-1:0] ledLeft;
  logic [ioPkg::dataWidth-1:0] ledRight;

  int fd;
  int scanCount;
  int numLines;
  int limit;
  int cycles;
  int passCount;
  int failCount;
  int testFails;
  logic [15:0] opName; // two character op code
  logic [8*24-1:0] testName;
  logic [8*128-1:0] lineBuf;
  logic [7:0] vAddr;
  logic [7:0] vData;
  logic [7:0] vExpect;
  logic [ioPkg::numButtons-1:0] vButtons;
  logic [7:0] readData;
  logic [7:0] snapshot [10]; // digits 0..7, then left and right LEDs

  fpgaIoTop dut_i (
    .clk(clk), .nrst(nrst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
    .buttons(buttons), .ack(ack), .datOut(datOut),
    .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3),
    .digit4(digit4), .digit5(digit5), .digit6(digit6), .digit7(digit7),
    .ledLeft(ledLeft), .ledRight(ledRight)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog, armed once the vector count is known
  initial begin
    cycles = 0;
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the test vectors did not finish", cycles);
    $display("TEST FAILED");
    $finish;
  end

  // front panel output by index
  function automatic logic [7:0] panelValue(input int idx);
    case (idx)
      0: return digit0;
      1: return digit1;
      2: return digit2;
      3: return digit3;
      4: return digit4;
      5: return digit5;
      6: return digit6;
      7: return digit7;
      8: return ledLeft;
      9: return ledRight;
      default: return 8'h00;
    endcase
  endfunction

  task automatic driveButtons(input logic [ioPkg::numButtons-1:0] pattern);
    @(posedge clk);
    buttons <= pattern;
    repeat (3) @(posedge clk); // through the synchronizer
  endtask

  // one Wishbone classic cycle, leaves cyc and stb up after ack
  task automatic busCycle(input logic write, input logic [7:0] addr, input logic [7:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we <= write;
    adr <= addr;
    datIn <= data;
    @(negedge clk);
    while (!ack && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!ack) begin
      $display("no ack from the DUT for address %h within 4 cycles in %0s", addr, testName);
      testFails++;
    end
    readData = datOut;
  endtask

  task automatic busRelease();
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we <= 1'b0;
  endtask

  task automatic runVector();
    testFails = 0;
    driveButtons(vButtons);
    for (int i = 0; i < 10; i++) begin
      snapshot[i] = panelValue(i);
    end
    case (opName)
      "wr": begin
        busCycle(1'b1, vAddr, vData);
        busRelease();
        @(negedge clk); // commit lands on the edge after ack
        for (int i = 0; i < 10; i++) begin
          if (i == int'(vAddr)) begin
            if (panelValue(i) !== vExpect) begin
              $display("[FAIL] %0s expected %h actual %h", testName, vExpect, panelValue(i));
              testFails++;
            end
          end else if (panelValue(i) !== snapshot[i]) begin
            $display("[FAIL] %0s output %0d expected %h actual %h", testName, i,
                     snapshot[i], panelValue(i));
            testFails++;
          end
        end
      end
      "rd": begin
        busCycle(1'b0, vAddr, 8'h00);
        busRelease();
        if (readData !== vExpect) begin
          $display("[FAIL] %0s expected %h actual %h", testName, vExpect, readData);
          testFails++;
        end
      end
      "dp": begin
        if (panelValue(int'(vAddr)) !== vExpect) begin
          $display("[FAIL] %0s expected %h actual %h", testName, vExpect,
                   panelValue(int'(vAddr)));
          testFails++;
        end
      end
      "wb": begin
        busCycle(1'b1, vAddr, vData);
        busCycle(1'b0, vAddr, 8'h00); // read follows with no idle cycle
        busRelease();
        if (readData !== vExpect) begin
          $display("[FAIL] %0s expected %h actual %h", testName, vExpect, readData);
          testFails++;
        end
      end
      default: begin
        $display("unknown operation in test %0s", testName);
        testFails++;
      end
    endcase
    if (testFails == 0) begin
      passCount++;
      $display("[PASS] %0s", testName);
    end else begin
      failCount++;
    end
  endtask

  initial begin
    nrst = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datIn = '0;
    buttons = '0;
    passCount = 0;
    failCount = 0;
    numLines = 0;
    fd = $fopen("dv/fpgaIo_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test vector file dv/fpgaIo_testdata.txt");
      failCount++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(lineBuf, fd) != 0) begin
          numLines++;
        end
      end
      $fclose(fd);
      limit = numLines * 12 + 50;
      repeat (8) @(posedge clk);
      nrst <= 1'b1;
      fd = $fopen("dv/fpgaIo_testdata.txt", "r");
      scanCount = $fscanf(fd, "%s", opName);
      while (scanCount == 1) begin
        if (opName == "//") begin
          void'($fgets(lineBuf, fd)); // column legend
        end else begin
          scanCount = $fscanf(fd, "%h %h %h %h %s", vAddr, vData, vButtons, vExpect, testName);
          if (scanCount != 5) begin
            $display("malformed test vector line after test %0s", testName);
            failCount++;
          end else begin
            runVector();
          end
        end
        scanCount = $fscanf(fd, "%s", opName);
      end
      $fclose(fd);
    end
    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dv/fpgaIo_testdata.txt
// op addr data buttons expect name, all values hex
// op wr write, rd read, dp output check (addr 0-9), wb write then read back to back
dp 00 00 000000 00 rstDigit0
dp 05 00 000000 00 rstDigit5
dp 08 00 000000 00 rstLedLeft
dp 09 00 000000 00 rstLedRight
rd 00 00 000000 00 rstRdDigit0
rd 07 00 000000 00 rstRdDigit7
rd 08 00 000000 00 rstRdLedLeft
rd 09 00 000000 00 rstRdLedRight
rd 0a 00 000000 00 rstRdBtn0
rd 0d 00 000000 00 rstRdIdx
wr 00 00 000000 bf wrVal00
wr 01 01 000000 06 wrVal01
wr 02 02 000000 5b wrVal02
wr 03 03 000000 4f wrVal03
wr 04 04 000000 66 wrVal04
wr 05 05 000000 6d wrVal05
wr 06 06 000000 7d wrVal06
wr 07 07 000000 07 wrVal07
rd 00 00 000000 bf rdDigit0
rd 03 00 000000 4f rdDigit3
wr 00 08 000000 7f wrVal08
wr 01 09 000000 6f wrVal09
wr 02 0a 000000 77 wrVal0A
wr 03 0b 000000 7c wrVal0B
wr 04 0c 000000 39 wrVal0C
wr 05 0d 000000 5e wrVal0D
wr 06 0e 000000 79 wrVal0E
wr 07 0f 000000 71 wrVal0F
wr 00 10 000000 76 wrValH
wr 01 11 000000 3e wrValW
wr 02 12 000000 5c wrValSmallO
wr 03 13 000000 50 wrValR
rd 02 00 000000 5c rdDigit2
wr 04 22 000000 fc wrRing22
wr 05 23 000000 f0 wrRing23
wr 06 24 000000 f8 wrRing24
wr 07 46 000000 d0 wrRPoint
wr 00 14 000000 ff wrUnlisted14
wr 01 55 000000 ff wrUnlisted55
rd 07 00 000000 d0 rdDigit7
wr 08 a5 000000 a5 wrLedLeft
wr 09 3c 000000 3c wrLedRight
rd 08 00 000000 a5 rdLedLeft
rd 09 00 000000 3c rdLedRight
rd 0a 00 1fa5c3 c3 rdBtnByte0
rd 0b 00 1fa5c3 a5 rdBtnByte1
rd 0c 00 1fa5c3 1f rdBtnByte2
rd 0d 00 1fa5c3 80 rdIdx0
rd 0d 00 1a0000 91 rdIdx17
rd 0d 00 100000 94 rdIdx20
rd 0d 00 000000 00 rdIdxNone
wr 30 12 000000 00 wrUnmapped
rd 30 00 000000 00 rdUnmapped
wb 02 0e 000000 79 wbDigit2
dp 02 00 000000 79 dpDigit2

// File: files.f
hw/ioPkg.sv
hw/ioBusPort.sv
hw/segGlyphEncoder.sv
hw/ioRegisterBank.sv
hw/buttonScanner.sv
hw/fpgaIoTop.sv
dv/fpgaIo_chk.sv
dv/fpgaIoTb.sv

// File: run.sh
#!/bin/sh
# build and run the front panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fpgaIoTb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/VfpgaIoTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0
